//--- adc_capture.f
rtl/adc_capture_pkg.sv
rtl/adc_sample_packer.sv
rtl/xfer_status_sync.sv
rtl/capture_ctrl.sv
rtl/adc_capture.sv
test/adc_capture_sva.sv
test/adc_capture_tb.sv

//--- rtl/adc_capture.sv
/*
 * adc capture write path, top level
 * packs converter samples into wide words, brings the memory-side
 * transfer status over to adc_clk and gates the words into fixed blocks
 */

`timescale 1ns/1ns

module adc_capture #(
  parameter int SAMPLE_WIDTH     = 16,
  parameter int SAMPLES_PER_WORD = 4,
  parameter int BLOCK_WORDS      = 8
) (
  // converter clock domain
  input  logic                                     adc_clk,
  input  logic                                     adc_rst,
  input  logic                                     adc_wr,
  input  logic [SAMPLE_WIDTH-1:0]                  adc_wdata,
  input  logic                                     capture_start,

  // memory clock domain
  input  logic                                     axi_clk,
  input  logic                                     axi_rst,
  input  logic [adc_capture_pkg::STATUS_WIDTH-1:0] axi_xfer_status,

  // block out, adc_clk
  output logic                                     word_valid,
  output logic [SAMPLE_WIDTH*SAMPLES_PER_WORD-1:0] word_data,
  output logic                                     word_last,
  output logic                                     capture_done,
  output logic                                     capture_ovf
);

  // packer to controller
  logic                                     pack_valid;
  logic [SAMPLE_WIDTH*SAMPLES_PER_WORD-1:0] pack_data;
  // synchronizer to controller
  logic                                     status_err;

  adc_sample_packer #(
    .SAMPLE_WIDTH     (SAMPLE_WIDTH),
    .SAMPLES_PER_WORD (SAMPLES_PER_WORD)
  ) u_packer (
    .adc_clk    (adc_clk),
    .adc_rst    (adc_rst),
    .adc_wr     (adc_wr),
    .adc_wdata  (adc_wdata),
    .pack_valid (pack_valid),
    .pack_data  (pack_data)
  );

  xfer_status_sync u_status (
    .axi_clk         (axi_clk),
    .axi_rst         (axi_rst),
    .axi_xfer_status (axi_xfer_status),
    .adc_clk         (adc_clk),
    .adc_rst         (adc_rst),
    .status_err      (status_err)
  );

  capture_ctrl #(
    .SAMPLE_WIDTH     (SAMPLE_WIDTH),
    .SAMPLES_PER_WORD (SAMPLES_PER_WORD),
    .BLOCK_WORDS      (BLOCK_WORDS)
  ) u_ctrl (
    .adc_clk       (adc_clk),
    .adc_rst       (adc_rst),
    .capture_start (capture_start),
    .pack_valid    (pack_valid),
    .pack_data     (pack_data),
    .status_err    (status_err),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .word_last     (word_last),
    .capture_done  (capture_done),
    .capture_ovf   (capture_ovf)
  );

endmodule

//--- rtl/adc_capture_pkg.sv
/*
 * adc capture shared definitions
 * holds the capture controller state encoding and the width of the
 * memory-side transfer status vector, shared by the RTL and the testbench
 */

package adc_capture_pkg;

  // ************************************************************************
  // transfer status
  // ************************************************************************

  // one bit per memory-side error source
  // any nonzero value counts as trouble
  localparam int STATUS_WIDTH = 4;

  // ************************************************************************
  // capture controller state
  // ************************************************************************

  // st_idle     waiting for capture_start
  // st_capture  passing packed words into the current block
  // st_overflow memory side reported an error, block is aborted
  typedef enum logic [1:0] {
    st_idle     = 2'd0,
    st_capture  = 2'd1,
    st_overflow = 2'd2
  } capture_state_t;

endpackage

//--- rtl/adc_sample_packer.sv
/*
 * adc sample packer
 * gathers SAMPLES_PER_WORD consecutive converter samples into one wide
 * memory word, oldest sample in the lowest slice, and pulses pack_valid
 * for one cycle when a word is complete
 */

`timescale 1ns/1ns

module adc_sample_packer #(
  parameter int SAMPLE_WIDTH     = 16,
  parameter int SAMPLES_PER_WORD = 4
) (
  input  logic                                 adc_clk,
  input  logic                                 adc_rst,

  // converter side
  input  logic                                 adc_wr,
  input  logic [SAMPLE_WIDTH-1:0]              adc_wdata,

  // packed word out
  output logic                                 pack_valid,
  output logic [SAMPLE_WIDTH*SAMPLES_PER_WORD-1:0] pack_data
);

  // ************************************************************************
  // local sizes
  // ************************************************************************

  localparam int WORD_WIDTH = SAMPLE_WIDTH * SAMPLES_PER_WORD;

  // counter needs at least one bit, even for a single sample per word
  localparam int CNT_WIDTH =
    (SAMPLES_PER_WORD > 1) ? $clog2(SAMPLES_PER_WORD) : 1;

  localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(SAMPLES_PER_WORD - 1);

  // position of the next sample inside the word
  logic [CNT_WIDTH-1:0] sample_cnt;

  // high on the write that completes a word
  logic                 word_end;

  assign word_end = adc_wr && (sample_cnt == CNT_LAST);

  // ************************************************************************
  // sample counter and word strobe
  // ************************************************************************

  // gaps in adc_wr just hold the count
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      sample_cnt <= '0;
      pack_valid <= 1'b0;
    end else begin
      pack_valid <= word_end;
      if (adc_wr) begin
        if (sample_cnt == CNT_LAST) begin
          sample_cnt <= '0;
        end else begin
          sample_cnt <= sample_cnt + 1'b1;
        end
      end
    end
  end

  // ************************************************************************
  // slice shift register
  // ************************************************************************

  generate
    if (SAMPLES_PER_WORD == 1) begin : g_direct
      // one sample per word, register it straight through
      always_ff @(posedge adc_clk) begin
        if (adc_wr) begin
          pack_data <= adc_wdata;
        end
      end
    end else begin : g_shift
      // new sample into the top slice, older slices move down one
      // so after a full word the oldest sits at the bottom
      always_ff @(posedge adc_clk) begin
        if (adc_wr) begin
          pack_data <= {adc_wdata, pack_data[WORD_WIDTH-1:SAMPLE_WIDTH]};
        end
      end
    end
  endgenerate

endmodule

//--- rtl/capture_ctrl.sv
/*
 * capture controller
 * lets exactly BLOCK_WORDS packed words through after a start pulse,
 * marks the last one, and aborts the block with a sticky overflow flag
 * when the synchronized memory status reports an error
 */

`timescale 1ns/1ns

module capture_ctrl #(
  parameter int SAMPLE_WIDTH     = 16,
  parameter int SAMPLES_PER_WORD = 4,
  parameter int BLOCK_WORDS      = 8
) (
  input  logic                                     adc_clk,
  input  logic                                     adc_rst,

  input  logic                                     capture_start,

  // from the packer
  input  logic                                     pack_valid,
  input  logic [SAMPLE_WIDTH*SAMPLES_PER_WORD-1:0] pack_data,

  // from the status synchronizer
  input  logic                                     status_err,

  // block out
  output logic                                     word_valid,
  output logic [SAMPLE_WIDTH*SAMPLES_PER_WORD-1:0] word_data,
  output logic                                     word_last,
  output logic                                     capture_done,
  output logic                                     capture_ovf
);

  // at least one counter bit for a single word block
  localparam int CNT_WIDTH = (BLOCK_WORDS > 1) ? $clog2(BLOCK_WORDS) : 1;

  localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(BLOCK_WORDS - 1);

  adc_capture_pkg::capture_state_t state;

  // words passed so far in this block
  logic [CNT_WIDTH-1:0] word_cnt;

  // ************************************************************************
  // control FSM
  // ************************************************************************

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      state        <= adc_capture_pkg::st_idle;
      word_cnt     <= '0;
      word_valid   <= 1'b0;
      word_last    <= 1'b0;
      capture_done <= 1'b0;
      capture_ovf  <= 1'b0;
    end else begin
      // strobes are single cycle
      word_valid   <= 1'b0;
      word_last    <= 1'b0;
      capture_done <= 1'b0;
      case (state)
        adc_capture_pkg::st_idle: begin
          // stray pack_valid is dropped here
          if (capture_start) begin
            state       <= adc_capture_pkg::st_capture;
            word_cnt    <= '0;
            capture_ovf <= 1'b0;
          end
        end
        adc_capture_pkg::st_capture: begin
          if (status_err) begin
            // error wins over a word in the same cycle
            state       <= adc_capture_pkg::st_overflow;
            capture_ovf <= 1'b1;
          end else if (pack_valid) begin
            word_valid <= 1'b1;
            word_cnt   <= word_cnt + 1'b1;
            if (word_cnt == CNT_LAST) begin
              word_last    <= 1'b1;
              capture_done <= 1'b1;
              state        <= adc_capture_pkg::st_idle;
            end
          end
        end
        adc_capture_pkg::st_overflow: begin
          // no words, close the block on the next cycle
          capture_done <= 1'b1;
          state        <= adc_capture_pkg::st_idle;
        end
        default: begin
          state <= adc_capture_pkg::st_idle;
        end
      endcase
    end
  end

  // ************************************************************************
  // word payload
  // ************************************************************************

  // follows pack_data on every accepted word, no reset needed
  always_ff @(posedge adc_clk) begin
    if (pack_valid && (state == adc_capture_pkg::st_capture)) begin
      word_data <= pack_data;
    end
  end

endmodule

//--- rtl/xfer_status_sync.sv
/*
 * transfer status synchronizer
 * accumulates the memory-side status bits on axi_clk and carries them
 * into adc_clk with a toggle and acknowledge handshake, then presents
 * the OR of the received bits as status_err
 */

`timescale 1ns/1ns

module xfer_status_sync (
  // memory side
  input  logic                                   axi_clk,
  input  logic                                   axi_rst,
  input  logic [adc_capture_pkg::STATUS_WIDTH-1:0] axi_xfer_status,

  // converter side
  input  logic                                   adc_clk,
  input  logic                                   adc_rst,
  output logic                                   status_err
);

  // ************************************************************************
  // axi side
  // ************************************************************************

  // sticky OR of everything seen since the last send
  logic [adc_capture_pkg::STATUS_WIDTH-1:0] axi_acc;
  // value held stable while a transfer is in flight
  logic [adc_capture_pkg::STATUS_WIDTH-1:0] axi_data;
  logic                                     axi_toggle;
  // acknowledge toggle coming back from adc_clk
  logic                                     axi_ack_m1;
  logic                                     axi_ack_m2;
  logic                                     axi_pending;

  // ************************************************************************
  // adc side
  // ************************************************************************

  logic                                     adc_tgl_m1;
  logic                                     adc_tgl_m2;
  logic                                     adc_tgl_m3;
  logic                                     adc_tgl_edge;
  logic [adc_capture_pkg::STATUS_WIDTH-1:0] adc_data;
  logic                                     adc_ack;

  // transfer in flight until the ack toggle matches the send toggle
  assign axi_pending = axi_toggle ^ axi_ack_m2;

  always_ff @(posedge axi_clk) begin
    if (axi_rst) begin
      axi_acc    <= '0;
      axi_data   <= '0;
      axi_toggle <= 1'b0;
      axi_ack_m1 <= 1'b0;
      axi_ack_m2 <= 1'b0;
    end else begin
      axi_ack_m1 <= adc_ack;
      axi_ack_m2 <= axi_ack_m1;
      if (!axi_pending) begin
        // launch the accumulated bits, start over with the current status
        axi_data   <= axi_acc;
        axi_toggle <= ~axi_toggle;
        axi_acc    <= axi_xfer_status;
      end else begin
        axi_acc    <= axi_acc | axi_xfer_status;
      end
    end
  end

  // toggle edge marks axi_data as settled
  assign adc_tgl_edge = adc_tgl_m2 ^ adc_tgl_m3;

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      adc_tgl_m1 <= 1'b0;
      adc_tgl_m2 <= 1'b0;
      adc_tgl_m3 <= 1'b0;
      adc_data   <= '0;
      adc_ack    <= 1'b0;
      status_err <= 1'b0;
    end else begin
      // two flops for metastability, third one for the edge
      adc_tgl_m1 <= axi_toggle;
      adc_tgl_m2 <= adc_tgl_m1;
      adc_tgl_m3 <= adc_tgl_m2;
      if (adc_tgl_edge) begin
        // multi-bit value is quiet here, sent before the toggle flipped
        adc_data <= axi_data;
        adc_ack  <= adc_tgl_m2;
      end
      // a zero transfer drops the flag again
      status_err <= |adc_data;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the adc capture testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module adc_capture_tb -f adc_capture.f -o adc_capture_sim

# the simulator status is not trusted alone, the pass line decides
sim_out=$(./obj_dir/adc_capture_sim) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "Regression passed"; then
  exit 0
else
  exit 1
fi

//--- test/adc_capture_sva.sv
/*
 * adc capture bound checker
 * concurrent checks on the capture controller timing, bound into the
 * top level so it sees the packer strobe and the FSM state
 */

`timescale 1ns/1ns

module adc_capture_sva (
  input logic                            adc_clk,
  input logic                            adc_rst,
  input logic                            capture_start,
  input logic                            pack_valid,
  input logic                            status_err,
  input logic                            word_valid,
  input logic                            word_last,
  input logic                            capture_done,
  input logic                            capture_ovf,
  input adc_capture_pkg::capture_state_t state
);

  // failures seen so far, watched by the testbench
  int fail_count = 0;

  // ************************************************************************
  // word timing
  // ************************************************************************

  // a packed word in st_capture leaves exactly one cycle later
  a_word_follows_pack: assert property (@(posedge adc_clk) disable iff (adc_rst)
    (state == adc_capture_pkg::st_capture && pack_valid && !status_err) |=> word_valid)
    else begin
      $error("word_valid missing one cycle after pack_valid in capture");
      fail_count++;
    end

  // and no word without such a packed word before it
  a_word_has_source: assert property (@(posedge adc_clk) disable iff (adc_rst)
    word_valid |-> $past(pack_valid && state == adc_capture_pkg::st_capture))
    else begin
      $error("word_valid without pack_valid in capture the cycle before");
      fail_count++;
    end

  a_last_with_done: assert property (@(posedge adc_clk) disable iff (adc_rst)
    word_last |-> (word_valid && capture_done))
    else begin
      $error("word_last without word_valid and capture_done");
      fail_count++;
    end

  // ************************************************************************
  // start pulses outside st_idle
  // ************************************************************************

  // quiet cycle in st_capture, a start must leave the block running
  a_start_ignored_capture: assert property (@(posedge adc_clk) disable iff (adc_rst)
    (state == adc_capture_pkg::st_capture && capture_start && !status_err && !pack_valid)
    |=> (state == adc_capture_pkg::st_capture && $stable(capture_ovf)))
    else begin
      $error("capture_start changed a running capture");
      fail_count++;
    end

  // aborted block still closes and keeps the flag
  a_start_ignored_ovf: assert property (@(posedge adc_clk) disable iff (adc_rst)
    (state == adc_capture_pkg::st_overflow && capture_start)
    |=> (state == adc_capture_pkg::st_idle && capture_ovf && capture_done))
    else begin
      $error("capture_start changed an aborted capture");
      fail_count++;
    end

endmodule

bind adc_capture adc_capture_sva u_sva (
  .adc_clk       (adc_clk),
  .adc_rst       (adc_rst),
  .capture_start (capture_start),
  .pack_valid    (pack_valid),
  .status_err    (status_err),
  .word_valid    (word_valid),
  .word_last     (word_last),
  .capture_done  (capture_done),
  .capture_ovf   (capture_ovf),
  .state         (u_ctrl.state)
);

//--- test/adc_capture_tb.sv
/*
 * adc capture testbench
 * random sample stream with gaps, a sample queue model for the packed
 * words, block length tracking, and an overflow abort with recovery
 */

`timescale 1ns/1ns

module adc_capture_tb;

  localparam int SAMPLE_WIDTH     = 16;
  localparam int SAMPLES_PER_WORD = 4;
  localparam int BLOCK_WORDS      = 8;
  localparam int WORD_WIDTH       = SAMPLE_WIDTH * SAMPLES_PER_WORD;

  logic                                     adc_clk = 1'b0;
  logic                                     axi_clk = 1'b0;
  logic                                     adc_rst;
  logic                                     axi_rst;
  logic                                     adc_wr;
  logic [SAMPLE_WIDTH-1:0]                  adc_wdata;
  logic                                     capture_start;
  logic [adc_capture_pkg::STATUS_WIDTH-1:0] axi_xfer_status;
  logic                                     word_valid;
  logic [WORD_WIDTH-1:0]                    word_data;
  logic                                     word_last;
  logic                                     capture_done;
  logic                                     capture_ovf;

  // model state
  logic [31:0]             lcg_state = 32'h561a_030e;
  logic [SAMPLE_WIDTH-1:0] samp_q[$];
  logic [WORD_WIDTH-1:0]   exp_word = '0;
  int                      started_cnt = 0;
  int                      done_cnt = 0;
  int                      word_cnt = 0;
  // request for a status pulse on the axi side
  logic                    err_req = 1'b0;

  adc_capture u_dut (
    .adc_clk         (adc_clk),
    .adc_rst         (adc_rst),
    .adc_wr          (adc_wr),
    .adc_wdata       (adc_wdata),
    .capture_start   (capture_start),
    .axi_clk         (axi_clk),
    .axi_rst         (axi_rst),
    .axi_xfer_status (axi_xfer_status),
    .word_valid      (word_valid),
    .word_data       (word_data),
    .word_last       (word_last),
    .capture_done    (capture_done),
    .capture_ovf     (capture_ovf)
  );

  always #20 adc_clk = ~adc_clk;
  always #15 axi_clk = ~axi_clk;

  // ************************************************************************
  // helpers
  // ************************************************************************

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic expect_bit(input string name, input logic actual, input logic expected);
    assert (actual === expected)
      else fail_stop($sformatf("CHECK FAILED %s expected %h actual %h", name, expected, actual));
  endtask

  // 0 done, 1 overflow, 2 status cleared, 3 any word
  function automatic bit cond_met(input int which);
    case (which)
      0:       return capture_done;
      1:       return capture_ovf;
      2:       return !u_dut.status_err;
      default: return word_valid;
    endcase
  endfunction

  task automatic wait_for(input int which, input int max_cycles, input string what);
    int n;
    n = 0;
    while (!cond_met(which)) begin
      if (n >= max_cycles) begin
        fail_stop($sformatf("timed out waiting for %s", what));
      end else begin
        n++;
        @(negedge adc_clk);
      end
    end
  endtask

  task automatic check_idle_outputs();
    expect_bit("word_valid", word_valid, 1'b0);
    expect_bit("word_last", word_last, 1'b0);
    expect_bit("capture_done", capture_done, 1'b0);
    expect_bit("capture_ovf", capture_ovf, 1'b0);
  endtask

  // one-cycle start pulse that also clears the overflow flag
  task automatic start_capture();
    capture_start = 1'b1;
    @(negedge adc_clk);
    capture_start = 1'b0;
    started_cnt++;
    expect_bit("capture_ovf", capture_ovf, 1'b0);
  endtask

  task automatic run_block(input bit stray_start);
    start_capture();
    if (stray_start) begin
      wait_for(3, 100, "first word of the block");
      capture_start = 1'b1;
      @(negedge adc_clk);
      capture_start = 1'b0;
    end
    wait_for(0, 400, "capture_done of a full block");
    repeat (3) @(negedge adc_clk);
  endtask

  // ************************************************************************
  // stimulus
  // ************************************************************************

  // samples with random gaps in about one cycle of four
  initial begin
    logic [31:0] rnd;
    adc_wr    = 1'b0;
    adc_wdata = '0;
    repeat (5) @(negedge adc_clk);
    forever begin
      @(negedge adc_clk);
      rnd       = lcg_next();
      adc_wr    = (rnd[29:28] != 2'b00);
      adc_wdata = rnd[31:16];
    end
  end

  // memory side drives a status pulse on request
  initial begin
    axi_rst         = 1'b1;
    axi_xfer_status = '0;
    repeat (5) @(negedge axi_clk);
    axi_rst = 1'b0;
    forever begin
      @(negedge axi_clk);
      axi_xfer_status = err_req ? 4'h4 : 4'h0;
    end
  end

  // ************************************************************************
  // model and checks
  // ************************************************************************

  // every accepted sample is queued
  // a full word puts the oldest sample into the lowest slice
  always @(posedge adc_clk) begin
    if (!adc_rst && adc_wr) begin
      samp_q.push_back(adc_wdata);
      if (samp_q.size() == SAMPLES_PER_WORD) begin
        for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
          exp_word[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = samp_q.pop_front();
        end
      end
    end
  end

  always @(negedge adc_clk) begin
    if (!adc_rst) begin
      assert (u_dut.u_sva.fail_count == 0)
        else fail_stop("a bound assertion on the controller failed");
      if (word_valid) begin
        assert (started_cnt != done_cnt)
          else fail_stop("word_valid seen while no capture was running");
        assert (word_data == exp_word)
          else fail_stop($sformatf("CHECK FAILED word_data expected %h actual %h",
                                   exp_word, word_data));
        word_cnt++;
        expect_bit("word_last", word_last, (word_cnt == BLOCK_WORDS));
      end
      if (capture_done) begin
        if (capture_ovf) begin
          expect_bit("word_valid", word_valid, 1'b0);
        end else begin
          expect_bit("word_valid", word_valid, 1'b1);
          assert (word_cnt == BLOCK_WORDS)
            else fail_stop($sformatf("CHECK FAILED word_cnt expected %h actual %h",
                                     BLOCK_WORDS, word_cnt));
        end
        word_cnt = 0;
        done_cnt++;
      end
    end
  end

  // ************************************************************************
  // main sequence
  // ************************************************************************

  initial begin
    adc_rst       = 1'b1;
    capture_start = 1'b0;
    repeat (5) begin
      @(negedge adc_clk);
      check_idle_outputs();
    end
    adc_rst = 1'b0;
    @(negedge adc_clk);
    check_idle_outputs();

    // two plain blocks and the second gets a stray start mid block
    run_block(1'b0);
    run_block(1'b1);

    // abort through the memory-side status
    start_capture();
    wait_for(3, 100, "first word before the error");
    err_req = 1'b1;
    @(negedge adc_clk);
    err_req = 1'b0;
    wait_for(1, 200, "capture_ovf after a status error");
    // FSM sits in st_overflow for this single cycle and must ignore a start
    capture_start = 1'b1;
    @(negedge adc_clk);
    capture_start = 1'b0;
    wait_for(0, 20, "capture_done after the abort");
    repeat (20) begin
      @(negedge adc_clk);
      expect_bit("capture_ovf", capture_ovf, 1'b1);
    end

    // zero status must reach adc_clk before the next block
    wait_for(2, 200, "status_err to clear");
    repeat (4) @(negedge adc_clk);
    run_block(1'b0);
    run_block(1'b0);

    if (u_dut.u_sva.fail_count != 0 || started_cnt != done_cnt) begin
      fail_stop("run ended with failed assertions or an open capture");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule
